// ==== Makefile ====
TOP = tb_gba_periph

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+source
source/gba_pkg.sv
source/gba_reg_if.sv
source/gba_bus_decode.sv
source/gba_timer_channel.sv
source/gba_interrupts.sv
source/gba_keypad.sv
source/gba_periph_top.sv
tb/tb_gba_periph.sv

// ==== source/gba_bus_decode.sv ====
//////////////////////////////////////////////////////////////////////
// register bus front end
// turns size and address into byte enables, strobes the addressed
// slave and returns registered read data one cycle later
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

module gba_bus_decode (
    input  logic                    clk16,
    input  logic                    resetn,
    input  logic                    bus_ena,
    input  logic                    bus_rnw,
    input  logic [`GBA_ADDR_W-1:0]  bus_adr,
    input  gba_pkg::acc_size_e      bus_acc,
    input  logic [`GBA_DATA_W-1:0]  bus_din,
    output logic [`GBA_DATA_W-1:0]  bus_dout,
    output logic                    bus_done,
    gba_reg_if.master               tmr [`GBA_TIMER_COUNT],
    gba_reg_if.master               intr,
    gba_reg_if.master               key
);

    logic [`GBA_ADDR_W-1:0]      word_adr;
    logic [3:0]                  be;
    logic                        wr_req;
    logic [`GBA_TIMER_COUNT-1:0] tmr_hit;
    logic [`GBA_TIMER_COUNT-1:0] tmr_wr;
    logic [`GBA_DATA_W-1:0]      tmr_rdata [`GBA_TIMER_COUNT];
    logic                        intr_hit;
    logic                        key_hit;
    logic [`GBA_DATA_W-1:0]      rd_mux;

    // lane enables from access size and low address bits
    function automatic logic [3:0] calc_be(input gba_pkg::acc_size_e size,
                                           input logic [1:0] adr);
        logic [3:0] ena;
        ena = 4'b0000;
        case (size)
            gba_pkg::ACC_BYTE: ena[adr] = 1'b1;
            gba_pkg::ACC_HALF: ena = adr[1] ? 4'b1100 : 4'b0011;
            gba_pkg::ACC_WORD: ena = 4'b1111;
            default:           ena = 4'b0000;
        endcase
        return ena;
    endfunction

    assign word_adr = {bus_adr[`GBA_ADDR_W-1:2], 2'b00};
    assign be       = calc_be(bus_acc, bus_adr[1:0]);
    assign wr_req   = bus_ena && !bus_rnw;

    assign intr_hit = (word_adr == `GBA_REG_IE) || (word_adr == `GBA_REG_IME);
    assign key_hit  = (word_adr == `GBA_REG_KEYINPUT);

    for (genvar i = 0; i < `GBA_TIMER_COUNT; i++) begin : g_tmr
        localparam logic [`GBA_ADDR_W-1:0] tmr_adr =
            `GBA_REG_TIMER_BASE + `GBA_ADDR_W'(4 * i);

        assign tmr_hit[i]      = (word_adr == tmr_adr);
        assign tmr_wr[i]       = wr_req && tmr_hit[i];
        assign tmr[i].wr       = tmr_wr[i];
        assign tmr[i].be       = be;
        assign tmr[i].wdata    = bus_din;
        assign tmr[i].word_sel = bus_adr[3];
        assign tmr_rdata[i]    = tmr[i].rdata;
    end

    assign intr.wr       = wr_req && intr_hit;
    assign intr.be       = be;
    assign intr.wdata    = bus_din;
    assign intr.word_sel = bus_adr[3];

    assign key.wr        = wr_req && key_hit;
    assign key.be        = be;
    assign key.wdata     = bus_din;
    assign key.word_sel  = bus_adr[3];

    // unmapped addresses fall through to zero
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < `GBA_TIMER_COUNT; i++) begin
            if (tmr_hit[i]) begin
                rd_mux = tmr_rdata[i];
            end
        end
        if (intr_hit) begin
            rd_mux = intr.rdata;
        end
        if (key_hit) begin
            rd_mux = key.rdata;
        end
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            bus_done <= 1'b0;
        end else begin
            bus_done <= bus_ena;
        end
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            bus_dout <= '0;
        end else if (bus_ena && bus_rnw) begin
            bus_dout <= rd_mux;
        end
    end

    // address map must never select two slaves at once
    a_one_slave_wr: assert property (@(posedge clk16) disable iff (!resetn)
        $onehot0({key.wr, intr.wr, tmr_wr}));

endmodule

// ==== source/gba_consts.svh ====
//////////////////////////////////////////////////////////////////////
// peripheral register map, widths and interrupt bit positions
//////////////////////////////////////////////////////////////////////
`ifndef GBA_CONSTS_SVH
`define GBA_CONSTS_SVH

`define GBA_ADDR_W          28
`define GBA_DATA_W          32
`define GBA_TIMER_COUNT     4

// register word addresses
`define GBA_REG_TIMER_BASE  28'h100
`define GBA_REG_KEYINPUT    28'h130
`define GBA_REG_IE          28'h200
`define GBA_REG_IME         28'h208

// IF/IE bit positions, timer n sits at TIMER0 + n
`define GBA_IRQ_VBLANK      0
`define GBA_IRQ_HBLANK      1
`define GBA_IRQ_VCOUNT      2
`define GBA_IRQ_TIMER0      3
`define GBA_IRQ_KEYPAD      12

`define GBA_IRQ_W           14
`define GBA_KEY_W           10

`endif

// ==== source/gba_interrupts.sv ====
//////////////////////////////////////////////////////////////////////
// interrupt controller
// IE, IF and IME registers and the registered CPU interrupt line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

module gba_interrupts (
    input  logic                        clk16,
    input  logic                        resetn,
    gba_reg_if.slave                    regs,
    input  logic [`GBA_TIMER_COUNT-1:0] timer_irq,
    input  logic                        key_irq,
    input  logic                        vblank,
    input  logic                        hblank,
    input  logic                        vcount,
    output logic                        irq
);

    gba_pkg::irq_vec_t ie;
    gba_pkg::irq_vec_t if_reg;
    gba_pkg::irq_vec_t src;
    gba_pkg::irq_vec_t clr;
    logic              ime;
    logic              wr_lo;
    logic              wr_ime;

    // word 0: IE low half, IF high half. word 1: IME
    assign regs.rdata = regs.word_sel ? {31'd0, ime} : {2'b00, if_reg, 2'b00, ie};

    assign wr_lo  = regs.wr && !regs.word_sel;
    assign wr_ime = regs.wr && regs.word_sel && regs.be[0];

    always_comb begin
        src = '0;
        src[`GBA_IRQ_VBLANK] = vblank;
        src[`GBA_IRQ_HBLANK] = hblank;
        src[`GBA_IRQ_VCOUNT] = vcount;
        for (int i = 0; i < `GBA_TIMER_COUNT; i++) begin
            src[`GBA_IRQ_TIMER0 + i] = timer_irq[i];
        end
        src[`GBA_IRQ_KEYPAD] = key_irq;
    end

    // IF acknowledge, write one to clear
    always_comb begin
        clr = '0;
        if (wr_lo && regs.be[2]) begin
            clr[7:0] = regs.wdata[23:16];
        end
        if (wr_lo && regs.be[3]) begin
            clr[13:8] = regs.wdata[29:24];
        end
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            ie     <= '0;
            if_reg <= '0;
            ime    <= 1'b0;
            irq    <= 1'b0;
        end else begin
            if (wr_lo && regs.be[0]) begin
                ie[7:0] <= regs.wdata[7:0];
            end
            if (wr_lo && regs.be[1]) begin
                ie[13:8] <= regs.wdata[13:8];
            end
            if (wr_ime) begin
                ime <= regs.wdata[0];
            end
            // a new request wins over a clear in the same cycle
            if_reg <= (if_reg & ~clr) | src;
            irq    <= ime && |(ie & if_reg);
        end
    end

    a_ime_gates_irq: assert property (@(posedge clk16) disable iff (!resetn)
        !ime |=> !irq);

endmodule

// ==== source/gba_keypad.sv ====
//////////////////////////////////////////////////////////////////////
// keypad input
// key synchronizer, KEYINPUT/KEYCNT and the key interrupt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

module gba_keypad (
    input  logic                  clk16,
    input  logic                  resetn,
    gba_reg_if.slave              regs,
    input  logic [`GBA_KEY_W-1:0] keys,
    output logic                  key_irq
);

    logic [`GBA_KEY_W-1:0] keys_meta;
    logic [`GBA_KEY_W-1:0] keys_sync;
    logic [`GBA_KEY_W-1:0] key_sel;
    logic                  key_en;
    logic                  key_and;
    logic                  cond;
    logic                  cond_q;

    // KEYINPUT is active low
    assign regs.rdata = {key_and, key_en, 4'b0000, key_sel, 6'b000000, ~keys_sync};

    // OR mode: any selected key, AND mode: every selected key
    assign cond = key_en && (key_and ? (|key_sel && ((keys_sync & key_sel) == key_sel))
                                     : |(keys_sync & key_sel));

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            keys_meta <= '0;
            keys_sync <= '0;
            key_sel   <= '0;
            key_en    <= 1'b0;
            key_and   <= 1'b0;
            cond_q    <= 1'b0;
            key_irq   <= 1'b0;
        end else begin
            keys_meta <= keys;
            keys_sync <= keys_meta;
            if (regs.wr && regs.be[2]) begin
                key_sel[7:0] <= regs.wdata[23:16];
            end
            if (regs.wr && regs.be[3]) begin
                key_sel[9:8] <= regs.wdata[25:24];
                key_en       <= regs.wdata[30];
                key_and      <= regs.wdata[31];
            end
            cond_q  <= cond;
            key_irq <= cond && !cond_q;
        end
    end

    a_irq_needs_enable: assert property (@(posedge clk16) disable iff (!resetn)
        key_irq |-> $past(key_en));

endmodule

// ==== source/gba_periph_top.sv ====
//////////////////////////////////////////////////////////////////////
// slow peripheral register block
// four cascaded timers, interrupt controller and keypad on one bus
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

module gba_periph_top (
    input  logic                   clk16,
    input  logic                   resetn,
    input  logic                   bus_ena,
    input  logic                   bus_rnw,
    input  logic [`GBA_ADDR_W-1:0] bus_adr,
    input  gba_pkg::acc_size_e     bus_acc,
    input  logic [`GBA_DATA_W-1:0] bus_din,
    output logic [`GBA_DATA_W-1:0] bus_dout,
    output logic                   bus_done,
    input  logic [`GBA_KEY_W-1:0]  keys,
    input  logic                   vblank,
    input  logic                   hblank,
    input  logic                   vcount,
    output logic                   irq
);

    logic [`GBA_TIMER_COUNT-1:0] tmr_ovf;
    logic [`GBA_TIMER_COUNT-1:0] tmr_irq;
    logic                        key_irq;

    gba_reg_if tmr_if [`GBA_TIMER_COUNT] ();
    gba_reg_if intr_if ();
    gba_reg_if key_if ();

    gba_bus_decode u_bus_decode (
        .clk16    (clk16),
        .resetn   (resetn),
        .bus_ena  (bus_ena),
        .bus_rnw  (bus_rnw),
        .bus_adr  (bus_adr),
        .bus_acc  (bus_acc),
        .bus_din  (bus_din),
        .bus_dout (bus_dout),
        .bus_done (bus_done),
        .tmr      (tmr_if),
        .intr     (intr_if),
        .key      (key_if)
    );

    ////////////////////////////////////////////////////////////////////
    // timers, each cascades from the previous one, timer 0 from timer 3
    ////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `GBA_TIMER_COUNT; i++) begin : g_timer
        gba_timer_channel u_timer (
            .clk16      (clk16),
            .resetn     (resetn),
            .regs       (tmr_if[i]),
            .cascade_in (tmr_ovf[(i + `GBA_TIMER_COUNT - 1) % `GBA_TIMER_COUNT]),
            .overflow   (tmr_ovf[i]),
            .irq        (tmr_irq[i])
        );
    end

    gba_interrupts u_interrupts (
        .clk16     (clk16),
        .resetn    (resetn),
        .regs      (intr_if),
        .timer_irq (tmr_irq),
        .key_irq   (key_irq),
        .vblank    (vblank),
        .hblank    (hblank),
        .vcount    (vcount),
        .irq       (irq)
    );

    gba_keypad u_keypad (
        .clk16   (clk16),
        .resetn  (resetn),
        .regs    (key_if),
        .keys    (keys),
        .key_irq (key_irq)
    );

endmodule

// ==== source/gba_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the peripheral register block
// bus access size, timer control byte and interrupt vector
//////////////////////////////////////////////////////////////////////
`include "gba_consts.svh"

package gba_pkg;

    // size field of a bus access
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_RSVD = 2'b11
    } acc_size_e;

    // TMxCNT_H low byte
    typedef struct packed {
        logic       start;
        logic       irq_en;
        logic [2:0] rsvd;
        logic       count_up;
        // 0: 1 cycle, 1: 64, 2: 256, 3: 1024
        logic [1:0] prescale;
    } timer_ctrl_t;

    typedef logic [`GBA_IRQ_W-1:0] irq_vec_t;

endpackage

// ==== source/gba_reg_if.sv ====
//////////////////////////////////////////////////////////////////////
// register slave port between the bus decoder and one peripheral
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

interface gba_reg_if;

    logic                   wr;
    logic [3:0]             be;
    logic [`GBA_DATA_W-1:0] wdata;
    // selects between the two words of a slave with two
    logic                   word_sel;
    logic [`GBA_DATA_W-1:0] rdata;

    modport master (
        output wr,
        output be,
        output wdata,
        output word_sel,
        input  rdata
    );

    // rdata is combinational from the slave's registers
    modport slave (
        input  wr,
        input  be,
        input  wdata,
        input  word_sel,
        output rdata
    );

endinterface

// ==== source/gba_timer_channel.sv ====
//////////////////////////////////////////////////////////////////////
// one 16-bit timer
// reload register, prescaler or cascade stepping, overflow interrupt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module gba_timer_channel (
    input  logic      clk16,
    input  logic      resetn,
    gba_reg_if.slave  regs,
    input  logic      cascade_in,
    output logic      overflow,
    output logic      irq
);

    logic [15:0]          reload;
    logic [15:0]          reload_nxt;
    logic [15:0]          counter;
    gba_pkg::timer_ctrl_t ctrl;
    gba_pkg::timer_ctrl_t ctrl_nxt;
    logic [9:0]           prescale_cnt;
    logic                 start_rise;
    logic                 tick;
    logic                 step;
    logic                 wrap;

    // low half is reload on write, counter on read
    assign regs.rdata = {8'h00, ctrl, counter};

    always_comb begin
        reload_nxt = reload;
        if (regs.wr && regs.be[0]) begin
            reload_nxt[7:0] = regs.wdata[7:0];
        end
        if (regs.wr && regs.be[1]) begin
            reload_nxt[15:8] = regs.wdata[15:8];
        end
    end

    always_comb begin
        ctrl_nxt = ctrl;
        if (regs.wr && regs.be[2]) begin
            ctrl_nxt      = gba_pkg::timer_ctrl_t'(regs.wdata[23:16]);
            ctrl_nxt.rsvd = 3'b000;
        end
    end

    assign start_rise = ctrl_nxt.start && !ctrl.start;

    always_comb begin
        case (ctrl.prescale)
            2'd0:    tick = 1'b1;
            2'd1:    tick = &prescale_cnt[5:0];
            2'd2:    tick = &prescale_cnt[7:0];
            default: tick = &prescale_cnt;
        endcase
    end

    assign step = ctrl.start && (ctrl.count_up ? cascade_in : tick);
    assign wrap = step && (counter == 16'hffff);

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            reload       <= '0;
            ctrl         <= '0;
            counter      <= '0;
            prescale_cnt <= '0;
            overflow     <= 1'b0;
            irq          <= 1'b0;
        end else begin
            reload   <= reload_nxt;
            ctrl     <= ctrl_nxt;
            overflow <= wrap && !start_rise;
            irq      <= wrap && !start_rise && ctrl.irq_en;
            if (start_rise) begin
                // fresh start, takes a reload written in the same access
                counter      <= reload_nxt;
                prescale_cnt <= '0;
            end else begin
                if (ctrl.start) begin
                    prescale_cnt <= prescale_cnt + 10'd1;
                end
                if (wrap) begin
                    counter <= reload;
                end else if (step) begin
                    counter <= counter + 16'd1;
                end
            end
        end
    end

    // back-to-back overflows need single-cycle prescale or cascade
    a_overflow_rate: assert property (@(posedge clk16) disable iff (!resetn)
        (overflow && $past(overflow)) |->
            $past(ctrl.prescale == 2'd0 || ctrl.count_up));

endmodule

// ==== tb/tb_gba_periph.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the peripheral register block
// bus registers, timers, interrupt controller and keypad
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "gba_consts.svh"

module tb_gba_periph;

    localparam int RESET_CYCLES = 16;
    // per test budget: registers, lanes, prescaler, cascade, clear, keypad, margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 80 + 60 + 520 + 120 + 80 + 160 + 200;

    logic                   clk16;
    logic                   resetn;
    logic                   bus_ena;
    logic                   bus_rnw;
    logic [`GBA_ADDR_W-1:0] bus_adr;
    gba_pkg::acc_size_e     bus_acc;
    logic [`GBA_DATA_W-1:0] bus_din;
    logic [`GBA_DATA_W-1:0] bus_dout;
    logic                   bus_done;
    logic [`GBA_KEY_W-1:0]  keys;
    logic                   vblank;
    logic                   hblank;
    logic                   vcount;
    logic                   irq;

    int seed = 96619;
    int err_cnt = 0;
    int test_cnt = 0;
    int fail_tests = 0;
    int cyc = 0;

    gba_periph_top u_gba_periph_top (
        .clk16    (clk16),
        .resetn   (resetn),
        .bus_ena  (bus_ena),
        .bus_rnw  (bus_rnw),
        .bus_adr  (bus_adr),
        .bus_acc  (bus_acc),
        .bus_din  (bus_din),
        .bus_dout (bus_dout),
        .bus_done (bus_done),
        .keys     (keys),
        .vblank   (vblank),
        .hblank   (hblank),
        .vcount   (vcount),
        .irq      (irq)
    );

    initial begin
        clk16 = 1'b0;
        forever #4 clk16 = ~clk16;
    end

    always @(posedge clk16) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // protocol and reset checks
    //////////////////////////////////////////////////////////////////////
    a_done_follows_ena: assert property (@(posedge clk16) disable iff (!resetn)
        bus_done == $past(bus_ena))
        else begin
            $display("Error: bus_done = %h, expected %h", bus_done, !bus_done);
            err_cnt++;
        end

    a_quiet_in_reset: assert property (@(posedge clk16) (!resetn && cyc >= 2) |->
        (!bus_done && !irq && !(|u_gba_periph_top.tmr_ovf)
         && !(|u_gba_periph_top.tmr_irq) && !u_gba_periph_top.key_irq))
        else begin
            $display("an output or interrupt pulse was active during reset");
            err_cnt++;
        end

    // one access, inputs move 1 ns after the edge
    task automatic bus_cycle(input logic rnw, input logic [`GBA_ADDR_W-1:0] adr,
                             input gba_pkg::acc_size_e acc,
                             input logic [`GBA_DATA_W-1:0] din,
                             output logic [`GBA_DATA_W-1:0] dout);
        int n;
        n = 0;
        @(posedge clk16);
        #1;
        bus_ena = 1'b1;
        bus_rnw = rnw;
        bus_adr = adr;
        bus_acc = acc;
        bus_din = din;
        @(posedge clk16);
        #1;
        bus_ena = 1'b0;
        while (!bus_done && n < 4) begin
            @(posedge clk16);
            #1;
            n++;
        end
        assert (bus_done) else begin
            $display("bus_done did not come back after an access to %h", adr);
            err_cnt++;
        end
        dout = bus_dout;
    endtask

    task automatic write_reg(input logic [`GBA_ADDR_W-1:0] adr,
                             input gba_pkg::acc_size_e acc,
                             input logic [`GBA_DATA_W-1:0] din);
        logic [`GBA_DATA_W-1:0] unused;
        bus_cycle(1'b0, adr, acc, din, unused);
    endtask

    task automatic read_reg(input logic [`GBA_ADDR_W-1:0] adr,
                            output logic [`GBA_DATA_W-1:0] dout);
        bus_cycle(1'b1, adr, gba_pkg::ACC_WORD, '0, dout);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wait_irq(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (irq !== level && n < max_cycles) begin
            @(posedge clk16);
            #1;
            n++;
        end
        assert (irq === level) else begin
            $display("irq did not go to %0d within %0d cycles", level, max_cycles);
            err_cnt++;
        end
    endtask

    // IF sits in the high half of the IE word
    task automatic poll_if(input int bitn, input int max_reads);
        logic [31:0] rd;
        int n;
        n = 0;
        rd = '0;
        while (!rd[16 + bitn] && n < max_reads) begin
            read_reg(`GBA_REG_IE, rd);
            n++;
        end
        assert (rd[16 + bitn]) else begin
            $display("IF bit %0d was not set after %0d reads", bitn, max_reads);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int start_err);
        test_cnt++;
        if (err_cnt == start_err) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - start_err);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic reg_access;
        int e0;
        logic [31:0] r_ie;
        logic [31:0] r_ime;
        logic [31:0] rd;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        e0 = err_cnt;
        r_ie = $random(seed);
        r_ime = $random(seed);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, r_ie);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE)", rd, {18'd0, r_ie[13:0]});
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, r_ime);
        read_reg(`GBA_REG_IME, rd);
        check_eq("bus_dout (IME)", rd, {31'd0, r_ime[0]});
        read_reg(28'h000, rd);
        check_eq("bus_dout (0x000)", rd, 32'd0);
        read_reg(28'h110, rd);
        check_eq("bus_dout (0x110)", rd, 32'd0);
        read_reg(28'h134, rd);
        check_eq("bus_dout (0x134)", rd, 32'd0);
        read_reg(28'h20c, rd);
        check_eq("bus_dout (0x20c)", rd, 32'd0);
        // three reads back to back, one new address per cycle
        @(posedge clk16);
        #1;
        bus_ena = 1'b1;
        bus_rnw = 1'b1;
        bus_acc = gba_pkg::ACC_WORD;
        bus_adr = `GBA_REG_IE;
        @(posedge clk16);
        #1;
        bus_adr = `GBA_REG_IME;
        d0 = bus_dout;
        @(posedge clk16);
        #1;
        bus_adr = 28'h140;
        d1 = bus_dout;
        @(posedge clk16);
        #1;
        bus_ena = 1'b0;
        d2 = bus_dout;
        check_eq("bus_done", {31'd0, bus_done}, 32'd1);
        check_eq("bus_dout (IE, burst)", d0, {18'd0, r_ie[13:0]});
        check_eq("bus_dout (IME, burst)", d1, {31'd0, r_ime[0]});
        check_eq("bus_dout (0x140, burst)", d2, 32'd0);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, 32'd0);
        end_test("register access", e0);
    endtask

    task automatic lane_enables;
        int e0;
        logic [31:0] rd;
        e0 = err_cnt;
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'h0000_1234);
        write_reg(`GBA_REG_IE + 28'd1, gba_pkg::ACC_BYTE, 32'h0000_ab00);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE byte 1)", rd, 32'h0000_2b34);
        write_reg(`GBA_REG_KEYINPUT, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_KEYINPUT + 28'd2, gba_pkg::ACC_HALF, 32'h0203_0000);
        // KEYINPUT half is read only
        write_reg(`GBA_REG_KEYINPUT, gba_pkg::ACC_HALF, 32'hffff_ffff);
        read_reg(`GBA_REG_KEYINPUT, rd);
        check_eq("bus_dout (KEYCNT half)", rd, 32'h0203_03ff);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_RSVD, 32'hffff_ffff);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE reserved size)", rd, 32'h0000_2b34);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_KEYINPUT, gba_pkg::ACC_WORD, 32'd0);
        end_test("byte enables", e0);
    endtask

    task automatic timer_prescale;
        int e0;
        int t0;
        int steps;
        int cnt;
        logic [31:0] rd;
        e0 = err_cnt;
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'h0000_0008);
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, 32'd1);
        // start, irq_en, prescale 1, reload 0xfff0
        write_reg(`GBA_REG_TIMER_BASE, gba_pkg::ACC_WORD, 32'h00c0_fff0);
        poll_if(`GBA_IRQ_TIMER0, 12);
        wait_irq(1'b1, 8);
        write_reg(`GBA_REG_TIMER_BASE, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_IE + 28'd2, gba_pkg::ACC_HALF, 32'h0008_0000);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, 32'd0);
        // timer 2 at prescale 64
        write_reg(`GBA_REG_TIMER_BASE + 28'h8, gba_pkg::ACC_WORD, 32'h0081_1000);
        t0 = cyc;
        repeat (320) @(posedge clk16);
        read_reg(`GBA_REG_TIMER_BASE + 28'h8, rd);
        steps = (cyc - t0) / 64;
        cnt = {16'd0, rd[15:0]};
        check_eq("TM2CNT_H", {24'd0, rd[23:16]}, 32'h81);
        assert (cnt >= 'h1000 + steps - 1 && cnt <= 'h1000 + steps + 1) else begin
            $display("Error: TM2CNT_L = %h, expected about %h", cnt, 'h1000 + steps);
            err_cnt++;
        end
        write_reg(`GBA_REG_TIMER_BASE + 28'h8, gba_pkg::ACC_WORD, 32'd0);
        end_test("timer prescaler", e0);
    endtask

    task automatic timer_cascade;
        int e0;
        int k;
        logic [31:0] rd;
        e0 = err_cnt;
        k = 20 + ($random(seed) & 15);
        // timer 1 counts timer 0 overflows
        write_reg(`GBA_REG_TIMER_BASE + 28'h4, gba_pkg::ACC_WORD, 32'h0084_0000);
        @(posedge clk16);
        #1;
        bus_ena = 1'b1;
        bus_rnw = 1'b0;
        bus_acc = gba_pkg::ACC_WORD;
        bus_adr = `GBA_REG_TIMER_BASE;
        bus_din = 32'h0080_ffff;
        @(posedge clk16);
        #1;
        bus_ena = 1'b0;
        repeat (k) begin
            @(posedge clk16);
            #1;
        end
        // stop edge still counts one overflow
        bus_ena = 1'b1;
        bus_din = 32'd0;
        @(posedge clk16);
        #1;
        bus_ena = 1'b0;
        read_reg(`GBA_REG_TIMER_BASE + 28'h4, rd);
        check_eq("bus_dout (TM1)", rd, {8'h00, 8'h84, 16'(k + 1)});
        write_reg(`GBA_REG_TIMER_BASE + 28'h4, gba_pkg::ACC_WORD, 32'd0);
        end_test("timer cascade", e0);
    endtask

    task automatic irq_clear;
        int e0;
        logic [31:0] rd;
        e0 = err_cnt;
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'h0000_0007);
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, 32'd1);
        @(posedge clk16);
        #1;
        vblank = 1'b1;
        hblank = 1'b1;
        vcount = 1'b1;
        @(posedge clk16);
        #1;
        vblank = 1'b0;
        hblank = 1'b0;
        vcount = 1'b0;
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE/IF)", rd, 32'h0007_0007);
        wait_irq(1'b1, 4);
        write_reg(`GBA_REG_IE + 28'd2, gba_pkg::ACC_HALF, 32'h0003_0000);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE/IF)", rd, 32'h0004_0007);
        check_eq("irq", {31'd0, irq}, 32'd1);
        write_reg(`GBA_REG_IE + 28'd2, gba_pkg::ACC_HALF, 32'h0004_0000);
        wait_irq(1'b0, 4);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE/IF)", rd, 32'h0000_0007);
        write_reg(`GBA_REG_IME, gba_pkg::ACC_WORD, 32'd0);
        write_reg(`GBA_REG_IE, gba_pkg::ACC_WORD, 32'd0);
        end_test("interrupt clear", e0);
    endtask

    task automatic keypad_irq;
        int e0;
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [`GBA_KEY_W-1:0] kv;
        e0 = err_cnt;
        rnd = $random(seed);
        kv = rnd[`GBA_KEY_W-1:0];
        @(posedge clk16);
        #1;
        keys = kv;
        // two synchronizer stages before KEYINPUT sees them
        repeat (3) @(posedge clk16);
        read_reg(`GBA_REG_KEYINPUT, rd);
        check_eq("bus_dout (KEYINPUT)", rd, {22'd0, ~kv});
        @(posedge clk16);
        #1;
        keys = '0;
        // OR mode on key 3
        write_reg(`GBA_REG_KEYINPUT + 28'd2, gba_pkg::ACC_HALF, 32'h4008_0000);
        @(posedge clk16);
        #1;
        keys = 10'h008;
        poll_if(`GBA_IRQ_KEYPAD, 8);
        @(posedge clk16);
        #1;
        keys = '0;
        write_reg(`GBA_REG_IE + 28'd2, gba_pkg::ACC_HALF, 32'h1000_0000);
        // AND mode on keys 0 and 1
        write_reg(`GBA_REG_KEYINPUT + 28'd2, gba_pkg::ACC_HALF, 32'hc003_0000);
        @(posedge clk16);
        #1;
        keys = 10'h001;
        repeat (6) @(posedge clk16);
        read_reg(`GBA_REG_IE, rd);
        check_eq("IF keypad bit", {31'd0, rd[16 + `GBA_IRQ_KEYPAD]}, 32'd0);
        @(posedge clk16);
        #1;
        keys = 10'h003;
        poll_if(`GBA_IRQ_KEYPAD, 8);
        write_reg(`GBA_REG_KEYINPUT, gba_pkg::ACC_WORD, 32'd0);
        @(posedge clk16);
        #1;
        keys = '0;
        write_reg(`GBA_REG_IE + 28'd2, gba_pkg::ACC_HALF, 32'h1000_0000);
        read_reg(`GBA_REG_IE, rd);
        check_eq("bus_dout (IE/IF)", rd, 32'd0);
        end_test("keypad", e0);
    endtask

    initial begin
        resetn  = 1'b0;
        bus_ena = 1'b0;
        bus_rnw = 1'b1;
        bus_adr = '0;
        bus_acc = gba_pkg::ACC_WORD;
        bus_din = '0;
        keys    = '0;
        vblank  = 1'b0;
        hblank  = 1'b0;
        vcount  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk16);
        #1;
        resetn = 1'b1;
        reg_access;
        lane_enables;
        timer_prescale;
        timer_cascade;
        irq_clear;
        keypad_irq;
        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk16);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
